/* files.f */
+incdir+testbench
design/slide_pkg.sv
design/gesture_decoder.sv
design/slide_sequencer.sv
design/frame_window.sv
design/slideshow_top.sv
testbench/tb_slideshow.sv

/* Makefile */
# Verilator build and run of the slideshow core testbench

VERILATOR ?= verilator
TOP       ?= tb_slideshow
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_vectors.svh */
/* Swipe table for img_count 3, applied in order after the slideshow has loaded
   Idle gaps of 3 or 20 put a swipe inside the lockout of the swipe before it */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are gesture code, idle cycles before it, end_frame after it, expected index
typedef struct packed {
	logic [7:0] gesture;
	logic [7:0] idle;
	logic       frame_end;
	logic [7:0] exp_img;
} row_t;

localparam int NUM_ROWS = 15;

row_t vectors [NUM_ROWS] = '{
	'{8'h1C, 8'd40, 1'b1, 8'd1},
	'{8'h1C, 8'd40, 1'b0, 8'd2},
	// West from the last image wraps to 0
	'{8'h1C, 8'd40, 1'b1, 8'd0},
	// East from 0 wraps to the last image
	'{8'h14, 8'd40, 1'b1, 8'd2},
	'{8'h14, 8'd40, 1'b0, 8'd1},
	// Locked out
	'{8'h1C, 8'd3,  1'b0, 8'd1},
	'{8'h14, 8'd40, 1'b1, 8'd0},
	// Locked out, window must still follow the index
	'{8'h14, 8'd3,  1'b1, 8'd0},
	// Unknown codes
	'{8'h20, 8'd40, 1'b0, 8'd0},
	'{8'h14, 8'd40, 1'b1, 8'd2},
	'{8'h1C, 8'd40, 1'b1, 8'd0},
	'{8'h1D, 8'd40, 1'b1, 8'd0},
	'{8'h1C, 8'd40, 1'b0, 8'd1},
	// Late in the lockout, still dropped
	'{8'h1C, 8'd20, 1'b1, 8'd1},
	'{8'h14, 8'd40, 1'b1, 8'd0}
};

`endif

/* testbench/tb_slideshow.sv */
/* Runs with img_count 3; the table's expected indices assume that count
   Inputs change and outputs are checked 1 ns after the rising edge */
`timescale 1ns/1ps

module tb_slideshow;

	localparam int NUM_IMAGES = 3;

	logic                CLOCK_33 = 1'b0;
	logic                iRSTN;
	logic                pixel_strobe;
	logic [7:0]          img_count;
	logic                touch_ready;
	slide_pkg::gesture_t gesture;
	logic                end_frame;
	logic                new_frame;
	logic                loading;
	slide_pkg::img_idx_t current_img;
	slide_pkg::addr_t    base_read_addr;
	slide_pkg::addr_t    max_read_addr;
	logic                read_load;

	logic [31:0] lfsr = 32'hf43b_0e39;
	// Window and index the DUT should show right now
	int          last_base = 0;
	logic [7:0]  last_img = 8'd0;

	`include "tb_vectors.svh"

	slideshow_top UUT (.*);

	// 4 ns period
	always #2 CLOCK_33 = ~CLOCK_33;

	// ==============================
	// Helpers
	// ==============================

	// Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// One clock; read_load must repeat last cycle's new_frame
	task automatic tick;
		logic       prev_new;
		logic [7:0] b;
		prev_new = new_frame;
		@(posedge CLOCK_33);
		#1;
		check_value("read_load", 32'(read_load), 32'(prev_new));
		draw_bits(1, b);
		// Random single-cycle frame starts
		new_frame = b[0] && !new_frame;
	endtask

	// Window only moves on end_frame
	task automatic check_window;
		check_value("base_read_addr", 32'(base_read_addr), 32'(last_base));
		check_value("max_read_addr", 32'(max_read_addr),
		            32'(last_base + slide_pkg::WORDS_PER_IMAGE));
	endtask

	// ==============================
	// Test phases
	// ==============================

	task automatic load_slideshow;
		logic [7:0] gap;
		int         total;
		total = int'(img_count) * slide_pkg::PIXELS_PER_IMAGE;
		for (int p = 0; p < total; p++) begin
			draw_bits(2, gap);
			repeat (gap) begin
				tick();
				check_value("loading", 32'(loading), 32'(p > 0));
			end
			pixel_strobe = 1'b1;
			// Swipes while loading must leave the index alone
			touch_ready  = (p == 10) || (p == 200);
			if (p == 10)
				gesture = slide_pkg::GESTURE_WEST;
			else
				gesture = slide_pkg::GESTURE_EAST;
			tick();
			pixel_strobe = 1'b0;
			touch_ready  = 1'b0;
			check_value("loading", 32'(loading), 32'h1);
			check_value("current_img", 32'(current_img), 32'h0);
		end
		// Settle period after the last pixel
		repeat (slide_pkg::SETTLE_CYCLES - 1) begin
			tick();
			check_value("loading", 32'(loading), 32'h1);
		end
		tick();
		check_value("loading", 32'(loading), 32'h0);
		check_value("current_img", 32'(current_img), 32'h0);
	endtask

	task automatic apply_row(input row_t r);
		repeat (r.idle) tick();
		touch_ready = 1'b1;
		gesture     = slide_pkg::gesture_t'(r.gesture);
		tick();
		touch_ready = 1'b0;
		// Old index through the swipe delay, new one the cycle after
		repeat (slide_pkg::SWIPE_DELAY) tick();
		check_value("current_img", 32'(current_img), 32'(last_img));
		tick();
		check_value("current_img", 32'(current_img), 32'(r.exp_img));
		last_img = r.exp_img;
		if (r.frame_end) begin
			end_frame = 1'b1;
			tick();
			end_frame = 1'b0;
			last_base = int'(r.exp_img) * slide_pkg::WORDS_PER_IMAGE;
		end
		check_window();
	endtask

	initial begin
		iRSTN        = 1'b0;
		pixel_strobe = 1'b0;
		img_count    = 8'(NUM_IMAGES);
		touch_ready  = 1'b0;
		gesture      = slide_pkg::GESTURE_EAST;
		end_frame    = 1'b0;
		new_frame    = 1'b0;
		repeat (8) @(posedge CLOCK_33);
		#1;
		iRSTN = 1'b1;
		check_value("loading", 32'(loading), 32'h0);
		check_value("current_img", 32'(current_img), 32'h0);
		check_value("read_load", 32'(read_load), 32'h0);
		check_window();
		load_slideshow();
		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(vectors[i]);
		$display("Done: no errors");
		$finish;
	end

	// Watchdog sized from the worst case of every phase, margin of two
	initial begin
		int budget;
		budget = 8 + 4 * NUM_IMAGES * slide_pkg::PIXELS_PER_IMAGE +
		         slide_pkg::SETTLE_CYCLES + slide_pkg::SWIPE_LOCKOUT;
		for (int i = 0; i < NUM_ROWS; i++)
			budget += int'(vectors[i].idle) + slide_pkg::SWIPE_DELAY + 3;
		#(2 * budget * 4);
		$display("Timeout: the test did not finish within %0d cycles", 2 * budget);
		$display("Done: errors found");
		$fatal(1);
	end

endmodule

/* design/slideshow_top.sv */
/* Slide selection core on CLOCK_33 only; all inputs are pulses or levels with no handshake
   img_count must be held constant after reset */
`timescale 1ns/1ps

module slideshow_top (
	input  logic                CLOCK_33,
	input  logic                iRSTN,
	input  logic                pixel_strobe,
	input  logic [7:0]          img_count,
	input  logic                touch_ready,
	input  slide_pkg::gesture_t gesture,
	input  logic                end_frame,
	input  logic                new_frame,
	output logic                loading,
	output slide_pkg::img_idx_t current_img,
	output slide_pkg::addr_t    base_read_addr,
	output slide_pkg::addr_t    max_read_addr,
	output logic                read_load
);

	// Debounced steps from decode to execute
	logic step_west;
	logic step_east;

	// ==============================
	// Decode, execute, result
	// ==============================

	gesture_decoder u_gesture_decoder (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.step_west   (step_west),
		.step_east   (step_east)
	);

	// Pixel count, loading flag, image index
	slide_sequencer u_slide_sequencer (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.pixel_strobe (pixel_strobe),
		.img_count    (img_count),
		.step_west    (step_west),
		.step_east    (step_east),
		.loading      (loading),
		.current_img  (current_img)
	);

	// Read window for the frame buffer
	frame_window u_frame_window (
		.CLOCK_33       (CLOCK_33),
		.iRSTN          (iRSTN),
		.current_img    (current_img),
		.end_frame      (end_frame),
		.new_frame      (new_frame),
		.base_read_addr (base_read_addr),
		.max_read_addr  (max_read_addr),
		.read_load      (read_load)
	);

endmodule

/* design/frame_window.sv */
/* Read window follows current_img only at end of frame, so a frame never mixes images
   read_load is new_frame delayed one cycle */
`timescale 1ns/1ps

module frame_window (
	input  logic                CLOCK_33,
	input  logic                iRSTN,
	input  slide_pkg::img_idx_t current_img,
	input  logic                end_frame,
	input  logic                new_frame,
	output slide_pkg::addr_t    base_read_addr,
	output slide_pkg::addr_t    max_read_addr,
	output logic                read_load
);

	slide_pkg::addr_t win_base;
	slide_pkg::addr_t win_max;

	// Window of the image selected right now
	assign win_base = slide_pkg::addr_t'(current_img) *
	                  slide_pkg::addr_t'(slide_pkg::WORDS_PER_IMAGE);
	assign win_max  = win_base + slide_pkg::addr_t'(slide_pkg::WORDS_PER_IMAGE);

	// ==============================
	// Window latch and FIFO reload
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			base_read_addr <= '0;
			max_read_addr  <= slide_pkg::addr_t'(slide_pkg::WORDS_PER_IMAGE);
			read_load      <= 1'b0;
		end else begin
			// Hold the window for the whole frame
			if (end_frame) begin
				base_read_addr <= win_base;
				max_read_addr  <= win_max;
			end
			// Flush the read FIFO one cycle into the new frame
			read_load <= new_frame;
		end
	end

	// Frame start is a single-cycle pulse, a longer one would reload the FIFO twice
	a_new_frame_pulse: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		new_frame |=> !new_frame);

endmodule

/* design/slide_sequencer.sv */
/* img_count must stay constant after reset and be at most MAX_IMAGES
   With img_count 0 nothing loads; pixels beyond the total are ignored */
`timescale 1ns/1ps

module slide_sequencer (
	input  logic                CLOCK_33,
	input  logic                iRSTN,
	input  logic                pixel_strobe,
	input  logic [7:0]          img_count,
	input  logic                step_west,
	input  logic                step_east,
	output logic                loading,
	output slide_pkg::img_idx_t current_img
);

	slide_pkg::load_state_t state;
	slide_pkg::pix_cnt_t    pix_cnt;
	slide_pkg::pix_cnt_t    pix_next;
	slide_pkg::pix_cnt_t    pix_total;
	slide_pkg::settle_cnt_t settle_cnt;
	slide_pkg::img_idx_t    img_last;
	logic                   have_images;

	// Total pixels of the whole slideshow
	assign pix_total   = slide_pkg::pix_cnt_t'(img_count) *
	                     slide_pkg::pix_cnt_t'(slide_pkg::PIXELS_PER_IMAGE);
	assign pix_next    = pix_cnt + slide_pkg::pix_cnt_t'(1);
	assign have_images = (img_count != 8'd0);
	// Highest valid index, wraps to all ones for a full 32 image show
	assign img_last    = img_count[slide_pkg::IMG_IDX_W-1:0] - slide_pkg::img_idx_t'(1);

	// ==============================
	// Load FSM and image index
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			state       <= slide_pkg::LOAD_IDLE;
			pix_cnt     <= '0;
			settle_cnt  <= '0;
			loading     <= 1'b0;
			current_img <= '0;
		end else begin
			case (state)
				// Count pixels until the last one of the last image
				slide_pkg::LOAD_IDLE,
				slide_pkg::LOAD_RECEIVING: begin
					if (pixel_strobe && have_images) begin
						pix_cnt <= pix_next;
						// Rises with the first counted pixel
						loading <= 1'b1;
						if (pix_next == pix_total)
							state <= slide_pkg::LOAD_SETTLE;
						else
							state <= slide_pkg::LOAD_RECEIVING;
					end
				end
				// Hold loading for the settle period
				slide_pkg::LOAD_SETTLE: begin
					if (settle_cnt == slide_pkg::settle_cnt_t'(slide_pkg::SETTLE_CYCLES - 1)) begin
						loading <= 1'b0;
						state   <= slide_pkg::LOAD_SHOWING;
					end else begin
						settle_cnt <= settle_cnt + slide_pkg::settle_cnt_t'(1);
					end
				end
				// Steps only act once the show is up
				slide_pkg::LOAD_SHOWING: begin
					if (step_west) begin
						if (current_img == img_last)
							current_img <= '0;
						else
							current_img <= current_img + slide_pkg::img_idx_t'(1);
					end else if (step_east) begin
						if (current_img == '0)
							current_img <= img_last;
						else
							current_img <= current_img - slide_pkg::img_idx_t'(1);
					end
				end
				default: state <= slide_pkg::LOAD_IDLE;
			endcase
		end
	end

	// Index must always point inside the loaded slideshow
	a_idx_range: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		(state == slide_pkg::LOAD_SHOWING) |-> (8'(current_img) < img_count));

endmodule

/* design/gesture_decoder.sv */
/* One accepted west or east swipe gives one step pulse SWIPE_DELAY cycles later
   Further swipes are dropped until SWIPE_LOCKOUT cycles have passed */
`timescale 1ns/1ps

module gesture_decoder (
	input  logic                CLOCK_33,
	input  logic                iRSTN,
	input  logic                touch_ready,
	input  slide_pkg::gesture_t gesture,
	output logic                step_west,
	output logic                step_east
);

	slide_pkg::swipe_state_t state;
	slide_pkg::swipe_cnt_t   hold_cnt;
	logic                    dir_west;
	logic                    is_west;
	logic                    is_east;
	logic                    accept;
	logic                    fire;

	// Only the two swipe codes count as a trigger
	assign is_west = (gesture == slide_pkg::GESTURE_WEST);
	assign is_east = (gesture == slide_pkg::GESTURE_EAST);
	assign accept  = touch_ready && (is_west || is_east) && (state == slide_pkg::SWIPE_READY);

	// ==============================
	// Delay and lockout timer
	// ==============================

	// Counter starts at 0 on the accepting edge
	// Delay and lockout are both read off it
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			state    <= slide_pkg::SWIPE_READY;
			hold_cnt <= '0;
		end else begin
			case (state)
				slide_pkg::SWIPE_READY: begin
					if (accept) begin
						state    <= slide_pkg::SWIPE_HOLD;
						hold_cnt <= '0;
					end
				end
				slide_pkg::SWIPE_HOLD: begin
					// Last lockout cycle, ready again after this edge
					if (hold_cnt == slide_pkg::swipe_cnt_t'(slide_pkg::SWIPE_LOCKOUT - 1)) begin
						state    <= slide_pkg::SWIPE_READY;
						hold_cnt <= '0;
					end else begin
						hold_cnt <= hold_cnt + slide_pkg::swipe_cnt_t'(1);
					end
				end
				default: state <= slide_pkg::SWIPE_READY;
			endcase
		end
	end

	// Direction of the swipe being timed
	always_ff @(posedge CLOCK_33) begin
		if (accept)
			dir_west <= is_west;
	end

	// Single cycle where the counter hits the delay
	assign fire      = (state == slide_pkg::SWIPE_HOLD) &&
	                   (hold_cnt == slide_pkg::swipe_cnt_t'(slide_pkg::SWIPE_DELAY));
	assign step_west = fire && dir_west;
	assign step_east = fire && !dir_west;

	// Each step goes back to a swipe of its own direction accepted SWIPE_DELAY cycles before
	a_west_src: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		step_west |-> $past(accept && is_west, slide_pkg::SWIPE_DELAY + 1));
	a_east_src: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		step_east |-> $past(accept && is_east, slide_pkg::SWIPE_DELAY + 1));

endmodule

/* design/slide_pkg.sv */
/* Image size and swipe times are scaled down so that the core can be simulated
   Each pixel takes two 16-bit frame-buffer words, and at most MAX_IMAGES images are held */
package slide_pkg;

	// ==============================
	// Image geometry
	// ==============================

	localparam int IMG_WIDTH        = 16;
	localparam int IMG_HEIGHT       = 8;
	localparam int PIXELS_PER_IMAGE = IMG_WIDTH * IMG_HEIGHT;
	// Two 16-bit words per pixel in the frame buffer
	localparam int WORDS_PER_IMAGE  = 2 * PIXELS_PER_IMAGE;
	localparam int MAX_IMAGES       = 32;

	// Field widths
	localparam int IMG_IDX_W        = $clog2(MAX_IMAGES);
	localparam int ADDR_W           = 24;
	// Must hold the full count MAX_IMAGES * PIXELS_PER_IMAGE
	localparam int PIX_CNT_W        = $clog2(MAX_IMAGES * PIXELS_PER_IMAGE + 1);

	// ==============================
	// Timing, in CLOCK_33 cycles
	// ==============================

	// Accepted swipe to step pulse
	localparam int SWIPE_DELAY      = 20;
	// Accepted swipe to next accept
	localparam int SWIPE_LOCKOUT    = 50;
	// Loading stays high this long after the last pixel
	localparam int SETTLE_CYCLES    = 51;

	localparam int SWIPE_CNT_W      = $clog2(SWIPE_LOCKOUT);
	localparam int SETTLE_CNT_W     = $clog2(SETTLE_CYCLES);

	// Sized vector types
	typedef logic [IMG_IDX_W-1:0]    img_idx_t;
	typedef logic [ADDR_W-1:0]       addr_t;
	typedef logic [PIX_CNT_W-1:0]    pix_cnt_t;
	typedef logic [SWIPE_CNT_W-1:0]  swipe_cnt_t;
	typedef logic [SETTLE_CNT_W-1:0] settle_cnt_t;

	// ==============================
	// Encodings
	// ==============================

	// Touch controller gesture codes, anything else is ignored
	typedef enum logic [7:0] {
		GESTURE_EAST = 8'h14,
		GESTURE_WEST = 8'h1C
	} gesture_t;

	typedef enum logic [0:0] {
		SWIPE_READY,
		SWIPE_HOLD
	} swipe_state_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_RECEIVING,
		LOAD_SETTLE,
		LOAD_SHOWING
	} load_state_t;

endpackage
